// File: src/mul_pkg.sv
// Multiply unit shared types
package mul_pkg;

  // operation codes of the integer multiply group
  typedef enum logic [1:0] {
    MUL    = 2'd0,
    MULH   = 2'd1,
    MULHSU = 2'd2,
    MULHU  = 2'd3
  } mul_op_e;

  // decoded control, travels with the captured operands
  typedef struct packed {
    // multiplicand (rs1) taken as signed
    logic signed_a;
    // multiplier (rs2) taken as signed
    logic signed_b;
    // return bits [2*XLEN-1:XLEN] instead of [XLEN-1:0]
    logic take_high;
  } mul_ctrl_t;

endpackage

// File: src/mul_decode.sv
// Multiply operation decode
`timescale 1ns/1ps

module mul_decode import mul_pkg::*; #(
  parameter int XLEN = 32
) (
  input  mul_op_e   op_i,
  output mul_ctrl_t ctrl_o
);

  // low half is the same for any signedness, so MUL runs as signed
  always_comb begin
    ctrl_o = '0;
    case (op_i)
      MUL: begin
        ctrl_o.signed_a  = 1'b1;
        ctrl_o.signed_b  = 1'b1;
        ctrl_o.take_high = 1'b0;
      end
      MULH: begin
        ctrl_o.signed_a  = 1'b1;
        ctrl_o.signed_b  = 1'b1;
        ctrl_o.take_high = 1'b1;
      end
      MULHSU: begin
        ctrl_o.signed_a  = 1'b1;
        ctrl_o.signed_b  = 1'b0;
        ctrl_o.take_high = 1'b1;
      end
      MULHU: begin
        ctrl_o.signed_a  = 1'b0;
        ctrl_o.signed_b  = 1'b0;
        ctrl_o.take_high = 1'b1;
      end
      default: begin
        ctrl_o = '0;
      end
    endcase
  end

  // decode has no width of its own, XLEN only sanity checked here
  initial begin
    if (XLEN % 2 != 0) begin
      $error("XLEN must be even for radix-4 recoding");
    end
  end

endmodule

// File: src/booth_encoder.sv
// Radix-4 Booth partial products
`timescale 1ns/1ps

module booth_encoder import mul_pkg::*; #(
  parameter int XLEN = 32
) (
  input  logic [XLEN-1:0]              op_a_i,
  input  logic [XLEN-1:0]              op_b_i,
  input  mul_ctrl_t                    ctrl_i,
  output logic [XLEN/2:0][2*XLEN+3:0]  pp_o
);

  localparam int NPP = XLEN / 2 + 1;
  localparam int W   = 2 * XLEN + 4;

  logic [XLEN:0]   a_ext;
  logic [XLEN+2:0] b_ext;
  logic [XLEN+1:0] a_one;
  logic [XLEN+1:0] a_two;

  // one extra bit on A carries the signedness
  assign a_ext = {ctrl_i.signed_a & op_a_i[XLEN-1], op_a_i};
  // B gets two extension bits on top and the implicit zero below
  assign b_ext = {{2{ctrl_i.signed_b & op_b_i[XLEN-1]}}, op_b_i, 1'b0};
  assign a_one = {a_ext[XLEN], a_ext};
  assign a_two = {a_ext, 1'b0};

  always_comb begin : booth_rows
    logic [2:0]      grp;
    logic [XLEN+1:0] mag;
    logic            neg;
    logic            neg_prev;
    logic [W-1:0]    row;

    neg_prev = 1'b0;
    for (int j = 0; j < NPP; j++) begin
      grp = b_ext[2*j +: 3];
      case (grp)
        3'b001, 3'b010: begin
          mag = a_one;
          neg = 1'b0;
        end
        3'b011: begin
          mag = a_two;
          neg = 1'b0;
        end
        3'b100: begin
          mag = a_two;
          neg = 1'b1;
        end
        3'b101, 3'b110: begin
          mag = a_one;
          neg = 1'b1;
        end
        default: begin
          mag = '0;
          neg = 1'b0;
        end
      endcase
      row = {{(W - XLEN - 2){mag[XLEN+1]}}, mag};
      if (neg) begin
        row = ~row;
      end
      // the +1 of the previous row's negation sits in the two free low bits
      row = (row << (2 * j)) | ((W'(neg_prev) << (2 * j)) >> 2);
      pp_o[j] = row;
      // top group is always 0 or +A, so its neg never needs a slot
      neg_prev = neg;
    end
  end

endmodule

// File: src/wallace_tree.sv
// Wallace carry-save reduction
`timescale 1ns/1ps

module wallace_tree #(
  parameter int XLEN = 32
) (
  input  logic [XLEN/2:0][2*XLEN+3:0] pp_i,
  output logic [2*XLEN+3:0]           sum_o,
  output logic [2*XLEN+3:0]           carry_o
);

  localparam int NPP = XLEN / 2 + 1;
  localparam int W   = 2 * XLEN + 4;

  // rows entering a given layer
  function automatic int rows_at(input int layer);
    int n;
    n = NPP;
    for (int i = 0; i < layer; i++) begin
      n = (n / 3) * 2 + n % 3;
    end
    return n;
  endfunction

  // layers needed to get down to a sum/carry pair
  function automatic int layer_count();
    int n;
    int l;
    n = NPP;
    l = 0;
    while (n > 2) begin
      n = (n / 3) * 2 + n % 3;
      l++;
    end
    return l;
  endfunction

  localparam int NLAYERS = layer_count();

  for (genvar l = 0; l < NLAYERS; l++) begin : g_layer
    localparam int NIN  = rows_at(l);
    localparam int NGRP = NIN / 3;
    localparam int NOUT = rows_at(l + 1);

    logic [NIN-1:0][W-1:0]  din;
    logic [NOUT-1:0][W-1:0] dout;

    if (l == 0) begin : g_src
      assign din = pp_i;
    end else begin : g_src
      assign din = g_layer[l-1].dout;
    end

    // 3:2 compressors, full adder per bit column
    for (genvar g = 0; g < NGRP; g++) begin : g_csa
      logic [W-1:0] x;
      logic [W-1:0] y;
      logic [W-1:0] z;
      logic [W-2:0] cy;

      assign x  = din[3*g];
      assign y  = din[3*g+1];
      assign z  = din[3*g+2];
      assign cy = (x[W-2:0] & y[W-2:0]) | (x[W-2:0] & z[W-2:0]) |
                  (y[W-2:0] & z[W-2:0]);
      assign dout[2*g]   = x ^ y ^ z;
      // carry weighs one column more
      assign dout[2*g+1] = {cy, 1'b0};
    end

    // rows that do not fill a group go straight down
    for (genvar k = 0; k < NIN - 3 * NGRP; k++) begin : g_pass
      assign dout[2*NGRP+k] = din[3*NGRP+k];
    end
  end

  assign sum_o   = g_layer[NLAYERS-1].dout[0];
  assign carry_o = g_layer[NLAYERS-1].dout[1];

endmodule

// File: src/mul_sequencer.sv
// Multiply operand capture and sequencing
`timescale 1ns/1ps

module mul_sequencer import mul_pkg::*; #(
  parameter int XLEN = 32
) (
  input  logic            clock,
  input  logic            reset,
  input  logic            in_valid_i,
  output logic            in_ready_o,
  input  logic            flush_i,
  input  mul_ctrl_t       ctrl_i,
  input  logic [XLEN-1:0] src_a_i,
  input  logic [XLEN-1:0] src_b_i,
  output logic [XLEN-1:0] op_a_o,
  output logic [XLEN-1:0] op_b_o,
  output mul_ctrl_t       ctrl_o,
  output logic            finish_o
);

  typedef enum logic [1:0] {
    S_IDLE   = 2'd0,
    S_STAGE1 = 2'd1,
    S_STAGE2 = 2'd2,
    S_STAGE3 = 2'd3
  } seq_state_e;

  seq_state_e state_q;
  logic       accept;

  assign in_ready_o = (state_q == S_IDLE);
  // flush wins over a new request
  assign accept     = in_valid_i & in_ready_o & ~flush_i;

  // tree settles over the three busy states
  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= S_IDLE;
    end else if (flush_i) begin
      state_q <= S_IDLE;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (accept) begin
            state_q <= S_STAGE1;
          end
        end
        S_STAGE1: state_q <= S_STAGE2;
        S_STAGE2: state_q <= S_STAGE3;
        S_STAGE3: state_q <= S_IDLE;
        default:  state_q <= S_IDLE;
      endcase
    end
  end

  // operand and control capture
  always_ff @(posedge clock) begin
    if (accept) begin
      op_a_o <= src_a_i;
      op_b_o <= src_b_i;
      ctrl_o <= ctrl_i;
    end
  end

  // a flush in the last stage must not produce a result
  assign finish_o = (state_q == S_STAGE3) & ~flush_i;

endmodule

// File: src/mul_result.sv
// Multiply final add and output
`timescale 1ns/1ps

module mul_result #(
  parameter int XLEN = 32
) (
  input  logic              clock,
  input  logic              reset,
  input  logic              finish_i,
  input  logic              take_high_i,
  input  logic [2*XLEN+3:0] sum_i,
  input  logic [2*XLEN+3:0] carry_i,
  output logic              out_valid_o,
  output logic [XLEN-1:0]   result_o
);

  logic [2*XLEN+3:0] total;
  logic [2*XLEN-1:0] product;

  // carry-propagate add, guard bits dropped
  assign total   = sum_i + carry_i;
  assign product = total[2*XLEN-1:0];

  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid_o <= 1'b0;
      result_o    <= '0;
    end else begin
      // single-cycle pulse, no back-pressure
      out_valid_o <= finish_i;
      if (finish_i) begin
        result_o <= take_high_i ? product[2*XLEN-1:XLEN] : product[XLEN-1:0];
      end
    end
  end

endmodule

// File: src/mul_top.sv
// Integer multiply unit top
`timescale 1ns/1ps

module mul_top import mul_pkg::*; #(
  parameter int XLEN = 32
) (
  input  logic            clock,
  input  logic            reset,
  input  logic            in_valid_i,
  output logic            in_ready_o,
  input  mul_op_e         op_i,
  input  logic [XLEN-1:0] src_a_i,
  input  logic [XLEN-1:0] src_b_i,
  input  logic            flush_i,
  output logic            out_valid_o,
  output logic [XLEN-1:0] result_o
);

  mul_ctrl_t                   dec_ctrl;
  mul_ctrl_t                   cap_ctrl;
  logic [XLEN-1:0]             op_a;
  logic [XLEN-1:0]             op_b;
  logic [XLEN/2:0][2*XLEN+3:0] pp;
  logic [2*XLEN+3:0]           tree_sum;
  logic [2*XLEN+3:0]           tree_carry;
  logic                        finish;

  mul_decode #(.XLEN(XLEN)) u_decode (
    .op_i   (op_i),
    .ctrl_o (dec_ctrl)
  );

  mul_sequencer #(.XLEN(XLEN)) u_sequencer (
    .clock      (clock),
    .reset      (reset),
    .in_valid_i (in_valid_i),
    .in_ready_o (in_ready_o),
    .flush_i    (flush_i),
    .ctrl_i     (dec_ctrl),
    .src_a_i    (src_a_i),
    .src_b_i    (src_b_i),
    .op_a_o     (op_a),
    .op_b_o     (op_b),
    .ctrl_o     (cap_ctrl),
    .finish_o   (finish)
  );

  // encoder and tree hang off the captured operands
  booth_encoder #(.XLEN(XLEN)) u_booth (
    .op_a_i (op_a),
    .op_b_i (op_b),
    .ctrl_i (cap_ctrl),
    .pp_o   (pp)
  );

  wallace_tree #(.XLEN(XLEN)) u_tree (
    .pp_i    (pp),
    .sum_o   (tree_sum),
    .carry_o (tree_carry)
  );

  mul_result #(.XLEN(XLEN)) u_result (
    .clock       (clock),
    .reset       (reset),
    .finish_i    (finish),
    .take_high_i (cap_ctrl.take_high),
    .sum_i       (tree_sum),
    .carry_i     (tree_carry),
    .out_valid_o (out_valid_o),
    .result_o    (result_o)
  );

endmodule

// File: dv/mul_top_chk.sv
// Multiply unit bound checks
`timescale 1ns/1ps

module mul_top_chk import mul_pkg::*; #(
  parameter int XLEN = 32
) (
  input logic            clock,
  input logic            reset,
  input logic            in_valid_i,
  input logic            in_ready_i,
  input mul_op_e         op_i,
  input logic [XLEN-1:0] src_a_i,
  input logic [XLEN-1:0] src_b_i,
  input logic            flush_i,
  input logic            out_valid_i,
  input logic [XLEN-1:0] result_i
);

  logic [XLEN-1:0] exp_q;
  mul_op_e         exp_op_q;
  logic [2:0]      age_q;
  logic            due_q;
  logic            accept;
  logic            chk_failed = 1'b0;

  // architectural result from operands widened to the full product width
  function automatic logic [XLEN-1:0] reference_result(input mul_op_e op,
                                                      input logic [XLEN-1:0] a,
                                                      input logic [XLEN-1:0] b);
    logic              sa;
    logic              sb;
    logic [2*XLEN-1:0] wa;
    logic [2*XLEN-1:0] wb;
    logic [2*XLEN-1:0] full;
    sa   = (op != MULHU);
    sb   = (op == MUL) || (op == MULH);
    wa   = {{XLEN{sa & a[XLEN-1]}}, a};
    wb   = {{XLEN{sb & b[XLEN-1]}}, b};
    full = wa * wb;
    if (op == MUL) begin
      return full[XLEN-1:0];
    end
    return full[2*XLEN-1:XLEN];
  endfunction

  assign accept = in_valid_i & in_ready_i & ~flush_i;

  // edges since acceptance or zero when nothing is in flight
  always_ff @(posedge clock) begin
    if (reset) begin
      age_q <= 3'd0;
      due_q <= 1'b0;
    end else begin
      due_q <= (age_q == 3'd3) & ~flush_i;
      if (accept) begin
        age_q    <= 3'd1;
        exp_q    <= reference_result(op_i, src_a_i, src_b_i);
        exp_op_q <= op_i;
      end else if (flush_i || age_q == 3'd3) begin
        age_q <= 3'd0;
      end else if (age_q != 3'd0) begin
        age_q <= age_q + 3'd1;
      end
    end
  end

  a_reset_state: assert property (@(posedge clock) reset |=> (!out_valid_i && in_ready_i))
    else begin
      chk_failed = 1'b1;
      $error("ERROR reset: expected valid 0 ready 1, actual valid %b ready %b",
             $sampled(out_valid_i), $sampled(in_ready_i));
    end

  // pulse exactly three edges after an unflushed acceptance
  a_pulse_timing: assert property (@(posedge clock) disable iff (reset)
      out_valid_i == due_q)
    else begin
      chk_failed = 1'b1;
      $error("ERROR timing: expected out_valid %b, actual %b",
             $sampled(due_q), $sampled(out_valid_i));
    end

  a_result_value: assert property (@(posedge clock) disable iff (reset)
      out_valid_i |-> (result_i == exp_q))
    else begin
      chk_failed = 1'b1;
      $error("ERROR %s: expected %h, actual %h", exp_op_q.name(),
             $sampled(exp_q), $sampled(result_i));
    end

  a_busy_ready: assert property (@(posedge clock) disable iff (reset)
      (age_q != 3'd0) |-> !in_ready_i)
    else begin
      chk_failed = 1'b1;
      $error("ERROR busy: expected in_ready 0, actual 1");
    end

  a_flush_idle: assert property (@(posedge clock) disable iff (reset)
      ((age_q != 3'd0) && flush_i) |=> in_ready_i)
    else begin
      chk_failed = 1'b1;
      $error("ERROR flush: expected in_ready 1, actual 0");
    end

endmodule

// File: dv/tb_mul_top.sv
// Multiply unit testbench
`timescale 1ns/1ps

module tb_mul_top import mul_pkg::*; ();

  localparam int XLEN        = 32;
  localparam int CLK_PERIOD  = 4;
  localparam int NUM_REQ     = 200;
  localparam int NUM_CORNER  = 100;
  localparam int WATCHDOG_NS = NUM_REQ * 8 * CLK_PERIOD + 50 * CLK_PERIOD;

  logic            clock;
  logic            reset;
  logic            in_valid_i;
  logic            in_ready_o;
  mul_op_e         op_i;
  logic [XLEN-1:0] src_a_i;
  logic [XLEN-1:0] src_b_i;
  logic            flush_i;
  logic            out_valid_o;
  logic [XLEN-1:0] result_o;
  int              seed;
  logic [XLEN-1:0] corners [5];

  mul_top #(.XLEN(XLEN)) u_dut (.*);

  bind mul_top mul_top_chk #(.XLEN(XLEN)) u_chk (
    .clock       (clock),
    .reset       (reset),
    .in_valid_i  (in_valid_i),
    .in_ready_i  (in_ready_o),
    .op_i        (op_i),
    .src_a_i     (src_a_i),
    .src_b_i     (src_b_i),
    .flush_i     (flush_i),
    .out_valid_i (out_valid_o),
    .result_i    (result_o)
  );

  always #(CLK_PERIOD / 2) clock = ~clock;

  // one edge plus the drive offset
  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  task automatic await_result();
    for (int n = 0; n < 8; n++) begin
      next_cycle();
      if (out_valid_o) begin
        return;
      end
    end
    $display("*** FAILED ***");
    $fatal(1, "no result pulse within 8 cycles of acceptance");
  endtask

  // flush_at 0 runs to completion, else flush n edges after acceptance
  task automatic run_request(input mul_op_e op, input logic [XLEN-1:0] a,
                             input logic [XLEN-1:0] b, input int flush_at);
    int waited;
    waited = 0;
    next_cycle();
    while (!in_ready_o) begin
      waited++;
      if (waited > 8) begin
        $display("*** FAILED ***");
        $fatal(1, "in_ready_o stayed low, request could not be issued");
      end
      next_cycle();
    end
    in_valid_i = 1'b1;
    op_i       = op;
    src_a_i    = a;
    src_b_i    = b;
    next_cycle();
    in_valid_i = 1'b0;
    if (flush_at > 0) begin
      repeat (flush_at - 1) begin
        next_cycle();
      end
      flush_i = 1'b1;
      next_cycle();
      flush_i = 1'b0;
    end else begin
      await_result();
    end
  endtask

  // first assertion failure ends the run
  always @(negedge clock) begin
    if (u_dut.u_chk.chk_failed) begin
      $display("*** FAILED ***");
      $fatal(1, "checker assertion failed");
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("*** FAILED ***");
    $fatal(1, "watchdog expired before all requests finished");
  end

  initial begin
    logic [31:0]     rnd;
    logic [XLEN-1:0] a_rnd;
    logic [XLEN-1:0] b_rnd;
    int              flush_at;
    clock      = 1'b0;
    reset      = 1'b1;
    in_valid_i = 1'b0;
    op_i       = MUL;
    src_a_i    = '0;
    src_b_i    = '0;
    flush_i    = 1'b0;
    seed       = 32'hc68318a5;
    corners[0] = '0;
    corners[1] = {{(XLEN-1){1'b0}}, 1'b1};
    corners[2] = '1;
    corners[3] = {1'b1, {(XLEN-1){1'b0}}};
    corners[4] = {1'b0, {(XLEN-1){1'b1}}};
    repeat (8) @(posedge clock);
    #1;
    reset = 1'b0;

    // every corner pair through every op
    for (int i = 0; i < 5; i++) begin
      for (int j = 0; j < 5; j++) begin
        for (int k = 0; k < 4; k++) begin
          run_request(mul_op_e'(2'(k)), corners[i], corners[j], 0);
        end
      end
    end

    // random operands, roughly one in eight flushed
    for (int n = 0; n < NUM_REQ - NUM_CORNER; n++) begin
      rnd      = $random(seed);
      a_rnd    = $random(seed);
      b_rnd    = $random(seed);
      flush_at = 0;
      if (rnd[2:0] == 3'd0) begin
        flush_at = 1 + int'(rnd[4:3]) % 3;
      end
      run_request(mul_op_e'(rnd[6:5]), a_rnd, b_rnd, flush_at);
    end

    repeat (4) next_cycle();
    if (u_dut.u_chk.chk_failed) begin
      $display("*** FAILED ***");
      $fatal(1, "checker assertion failed");
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

// File: vlog.f
src/mul_pkg.sv
src/mul_decode.sv
src/booth_encoder.sv
src/wallace_tree.sv
src/mul_sequencer.sv
src/mul_result.sv
src/mul_top.sv
dv/mul_top_chk.sv
dv/tb_mul_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_mul_top
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --assert --timing -j 0 --Mdir $(OBJ_DIR) --top-module $(TOP)
RUN_FLAGS := +verilator+error+limit+100

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard src/*.sv dv/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: compile
	./$(BIN) $(RUN_FLAGS)

clean:
	rm -rf $(OBJ_DIR)
